// ==== csr_pkg.sv ====
package csr_pkg;

    typedef logic [13:0] csr_num_t;

    // CSR numbers
    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;
    localparam csr_num_t CSR_TID    = 14'h040;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    // Exception codes
    localparam logic [5:0] ECODE_ADE     = 6'h08;
    localparam logic [5:0] ECODE_ALE     = 6'h09;
    localparam logic [8:0] ESUBCODE_ADEF = 9'h000;

    // Field positions and widths
    localparam int INT_BITS      = 13;
    localparam int TIMER_IRQ_BIT = 11;
    localparam int EENTRY_VA_LSB = 6;
    localparam int TICLR_CLR_BIT = 0;

    localparam logic [31:0] TIMER_IDLE = 32'hffff_ffff;

    typedef struct packed {
        logic crmd;
        logic prmd;
        logic ecfg;
        logic estat;
        logic era;
        logic badv;
        logic eentry;
        logic save0;
        logic save1;
        logic save2;
        logic save3;
        logic tid;
        logic tcfg;
        logic tval;
        logic ticlr;
    } csr_sel_t;

    // One write word, seen through the layout of the register it targets
    typedef union packed {
        struct packed {
            logic [28:0] rsvd;
            logic        ie;
            logic [1:0]  plv;
        } crmd_view;
        struct packed {
            logic [28:0] rsvd;
            logic        pie;
            logic [1:0]  pplv;
        } prmd_view;
        struct packed {
            logic [29:0] rsvd;
            logic [1:0]  is10;
        } estat_view;
        struct packed {
            logic [29:0] initval;
            logic        periodic;
            logic        en;
        } tcfg_view;
        logic [31:0] raw;
    } csr_word_u;

    typedef struct packed {
        logic        we;
        logic [31:0] wmask;
        csr_word_u   wvalue;
    } csr_wr_t;

    typedef struct packed {
        logic        ex;
        logic        ertn;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] pc;
        logic [31:0] vaddr;
    } exc_req_t;

    typedef struct packed {
        logic [1:0]                  plv;
        logic                        ie;
        logic [1:0]                  pplv;
        logic                        pie;
        logic [INT_BITS-1:0]         lie;
        logic [INT_BITS-1:0]         estat_is;
        logic [5:0]                  ecode;
        logic [8:0]                  esubcode;
        logic [31:0]                 era;
        logic [31:0]                 badv;
        logic [31-EENTRY_VA_LSB:0]   eentry_va;
    } exc_rd_t;

    typedef struct packed {
        logic [31:0] tcfg;
        logic [31:0] tval;
    } timer_rd_t;

    typedef struct packed {
        logic [31:0] save0;
        logic [31:0] save1;
        logic [31:0] save2;
        logic [31:0] save3;
        logic [31:0] tid;
    } save_rd_t;

    function automatic logic [31:0] masked_merge(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [31:0] mask
    );
        return (mask & new_val) | (~mask & old_val);
    endfunction

endpackage

// ==== csr_addr_decode.sv ====
module csr_addr_decode
    import csr_pkg::*;
(
    input  csr_num_t csr_num,
    output csr_sel_t sel
);

    // Unknown numbers leave every bit low
    assign sel.crmd   = (csr_num == CSR_CRMD);
    assign sel.prmd   = (csr_num == CSR_PRMD);
    assign sel.ecfg   = (csr_num == CSR_ECFG);
    assign sel.estat  = (csr_num == CSR_ESTAT);
    assign sel.era    = (csr_num == CSR_ERA);
    assign sel.badv   = (csr_num == CSR_BADV);
    assign sel.eentry = (csr_num == CSR_EENTRY);

    assign sel.save0  = (csr_num == CSR_SAVE0);
    assign sel.save1  = (csr_num == CSR_SAVE1);
    assign sel.save2  = (csr_num == CSR_SAVE2);
    assign sel.save3  = (csr_num == CSR_SAVE3);
    assign sel.tid    = (csr_num == CSR_TID);

    // Timer block
    assign sel.tcfg   = (csr_num == CSR_TCFG);
    assign sel.tval   = (csr_num == CSR_TVAL);
    assign sel.ticlr  = (csr_num == CSR_TICLR);

endmodule

// ==== csr_exc_state.sv ====
module csr_exc_state
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  csr_wr_t     wr,
    input  csr_sel_t    sel,
    input  exc_req_t    exc,
    input  logic        timer_zero,
    output exc_rd_t     rd,
    output logic [31:0] ex_entry,
    output logic [31:0] ertn_pc,
    output logic        has_int
);

    logic [1:0]                crmd_plv;
    logic                      crmd_ie;
    logic [1:0]                prmd_pplv;
    logic                      prmd_pie;
    logic [INT_BITS-1:0]       ecfg_lie;
    logic [1:0]                estat_is10;
    logic                      estat_timer;
    logic [5:0]                estat_ecode;
    logic [8:0]                estat_esubcode;
    logic [31:0]               era;
    logic [31:0]               badv;
    logic [31-EENTRY_VA_LSB:0] eentry_va;

    csr_word_u   crmd_next;
    csr_word_u   prmd_next;
    csr_word_u   estat_next;
    logic [31:0] ecfg_next;
    logic [31:0] eentry_next;
    logic        addr_err;
    logic        ticlr_clr;
    logic [INT_BITS-1:0] estat_is;

    assign crmd_next.raw  = masked_merge({29'b0, crmd_ie, crmd_plv}, wr.wvalue.raw, wr.wmask);
    assign prmd_next.raw  = masked_merge({29'b0, prmd_pie, prmd_pplv}, wr.wvalue.raw, wr.wmask);
    assign estat_next.raw = masked_merge({30'b0, estat_is10}, wr.wvalue.raw, wr.wmask);
    assign ecfg_next      = masked_merge({{(32-INT_BITS){1'b0}}, ecfg_lie},
                                         wr.wvalue.raw, wr.wmask);
    assign eentry_next    = masked_merge({eentry_va, {EENTRY_VA_LSB{1'b0}}},
                                         wr.wvalue.raw, wr.wmask);

    assign addr_err  = (exc.ecode == ECODE_ADE) || (exc.ecode == ECODE_ALE);
    assign ticlr_clr = wr.we && sel.ticlr && wr.wmask[TICLR_CLR_BIT]
                       && wr.wvalue.raw[TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (exc.ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (exc.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr.we && sel.crmd) begin
            crmd_plv <= crmd_next.crmd_view.plv;
            crmd_ie  <= crmd_next.crmd_view.ie;
        end
    end

    // Privilege push on exception entry
    always_ff @(posedge clk) begin
        if (exc.ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr.we && sel.prmd) begin
            prmd_pplv <= prmd_next.prmd_view.pplv;
            prmd_pie  <= prmd_next.prmd_view.pie;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
        end else if (wr.we && sel.ecfg) begin
            ecfg_lie <= ecfg_next[INT_BITS-1:0];
        end
    end

    // Software interrupt bits
    always_ff @(posedge clk) begin
        if (reset) begin
            estat_is10 <= 2'b0;
        end else if (wr.we && sel.estat) begin
            estat_is10 <= estat_next.estat_view.is10;
        end
    end

    // Timer interrupt, set wins over clear
    always_ff @(posedge clk) begin
        if (reset) begin
            estat_timer <= 1'b0;
        end else if (timer_zero) begin
            estat_timer <= 1'b1;
        end else if (ticlr_clr) begin
            estat_timer <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (exc.ex) begin
            estat_ecode    <= exc.ecode;
            estat_esubcode <= exc.esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (exc.ex) begin
            era <= exc.pc;
        end else if (wr.we && sel.era) begin
            era <= masked_merge(era, wr.wvalue.raw, wr.wmask);
        end
    end

    // Fetch address errors report the pc itself
    always_ff @(posedge clk) begin
        if (exc.ex && addr_err) begin
            badv <= (exc.ecode == ECODE_ADE && exc.esubcode == ESUBCODE_ADEF) ?
                    exc.pc : exc.vaddr;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.we && sel.eentry) begin
            eentry_va <= eentry_next[31:EENTRY_VA_LSB];
        end
    end

    // Lines 10:2 and 12 are hardware and IPI interrupts, tied off
    assign estat_is = {1'b0, estat_timer, 9'b0, estat_is10};

    assign ex_entry = {eentry_va, {EENTRY_VA_LSB{1'b0}}};
    assign ertn_pc  = era;
    assign has_int  = ((estat_is[TIMER_IRQ_BIT:0] & ecfg_lie[TIMER_IRQ_BIT:0]) != '0)
                      && crmd_ie;

    assign rd.plv       = crmd_plv;
    assign rd.ie        = crmd_ie;
    assign rd.pplv      = prmd_pplv;
    assign rd.pie       = prmd_pie;
    assign rd.lie       = ecfg_lie;
    assign rd.estat_is  = estat_is;
    assign rd.ecode     = estat_ecode;
    assign rd.esubcode  = estat_esubcode;
    assign rd.era       = era;
    assign rd.badv      = badv;
    assign rd.eentry_va = eentry_va;

    a_ex_clears_crmd: assert property (@(posedge clk) disable iff (reset)
        exc.ex |=> (crmd_plv == 2'b0 && !crmd_ie))
        else $error("CRMD not cleared after exception entry");

    // ie has to be set already, or be set by this edge's return or write
    a_int_needs_ie: assert property (@(posedge clk) disable iff (reset)
        $rose(has_int) |-> $past(crmd_ie) || $past(exc.ertn) || $past(wr.we && sel.crmd))
        else $error("has_int rose with interrupts disabled");

endmodule

// ==== csr_timer.sv ====
module csr_timer
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  csr_wr_t   wr,
    input  csr_sel_t  sel,
    output timer_rd_t rd,
    output logic      timer_zero
);

    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    logic [31:0] count;
    logic        tcfg_wr;
    csr_word_u   tcfg_next;

    assign tcfg_wr = wr.we && sel.tcfg;
    assign tcfg_next.raw = masked_merge({tcfg_initval, tcfg_periodic, tcfg_en},
                                        wr.wvalue.raw, wr.wmask);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en <= 1'b0;
        end else if (tcfg_wr) begin
            tcfg_en <= tcfg_next.tcfg_view.en;
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_wr) begin
            tcfg_periodic <= tcfg_next.tcfg_view.periodic;
            tcfg_initval  <= tcfg_next.tcfg_view.initval;
        end
    end

    // One-shot mode wraps from zero to all ones and parks there
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= TIMER_IDLE;
        end else if (tcfg_wr && tcfg_next.tcfg_view.en) begin
            count <= {tcfg_next.tcfg_view.initval, 2'b00};
        end else if (tcfg_en && count != TIMER_IDLE) begin
            if (count == 32'b0 && tcfg_periodic) begin
                count <= {tcfg_initval, 2'b00};
            end else begin
                count <= count - 32'd1;
            end
        end
    end

    assign timer_zero = (count == 32'b0);

    assign rd.tcfg = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign rd.tval = count;

    a_idle_holds: assert property (@(posedge clk) disable iff (reset)
        (count == TIMER_IDLE && !tcfg_wr) |=> count == TIMER_IDLE)
        else $error("stopped timer left the idle value");

endmodule

// ==== csr_save_regs.sv ====
module csr_save_regs
    import csr_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  csr_wr_t  wr,
    input  csr_sel_t sel,
    output save_rd_t rd
);

    logic [31:0] save_q [4];
    logic [31:0] tid;
    logic [3:0]  save_sel;

    assign save_sel = {sel.save3, sel.save2, sel.save1, sel.save0};

    // Scratch words for the exception handler
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr.we && save_sel[i]) begin
                save_q[i] <= masked_merge(save_q[i], wr.wvalue.raw, wr.wmask);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= 32'b0;
        end else if (wr.we && sel.tid) begin
            tid <= masked_merge(tid, wr.wvalue.raw, wr.wmask);
        end
    end

    assign rd.save0 = save_q[0];
    assign rd.save1 = save_q[1];
    assign rd.save2 = save_q[2];
    assign rd.save3 = save_q[3];
    assign rd.tid   = tid;

endmodule

// ==== csr_read_mux.sv ====
module csr_read_mux
    import csr_pkg::*;
(
    input  csr_sel_t    sel,
    input  exc_rd_t     exc_rd,
    input  timer_rd_t   timer_rd,
    input  save_rd_t    save_rd,
    output logic [31:0] rvalue
);

    logic [31:0] crmd_word;
    logic [31:0] prmd_word;
    logic [31:0] ecfg_word;
    logic [31:0] estat_word;
    logic [31:0] eentry_word;

    // DA reads as one
    assign crmd_word   = {28'b0, 1'b1, exc_rd.ie, exc_rd.plv};
    assign prmd_word   = {29'b0, exc_rd.pie, exc_rd.pplv};
    assign ecfg_word   = {{(32-INT_BITS){1'b0}}, exc_rd.lie};
    assign estat_word  = {1'b0, exc_rd.esubcode, exc_rd.ecode, 3'b0, exc_rd.estat_is};
    assign eentry_word = {exc_rd.eentry_va, {EENTRY_VA_LSB{1'b0}}};

    // TICLR has no term, it reads zero
    assign rvalue = {32{sel.crmd}}   & crmd_word
                  | {32{sel.prmd}}   & prmd_word
                  | {32{sel.ecfg}}   & ecfg_word
                  | {32{sel.estat}}  & estat_word
                  | {32{sel.era}}    & exc_rd.era
                  | {32{sel.badv}}   & exc_rd.badv
                  | {32{sel.eentry}} & eentry_word
                  | {32{sel.save0}}  & save_rd.save0
                  | {32{sel.save1}}  & save_rd.save1
                  | {32{sel.save2}}  & save_rd.save2
                  | {32{sel.save3}}  & save_rd.save3
                  | {32{sel.tid}}    & save_rd.tid
                  | {32{sel.tcfg}}   & timer_rd.tcfg
                  | {32{sel.tval}}   & timer_rd.tval;

    // The AND-OR select breaks if the decoder ever raises two lines
    always_comb begin
        a_sel_onehot: assert ($onehot0(sel))
            else $error("register select is not one-hot");
    end

endmodule

// ==== csr_top.sv ====
module csr_top
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        csr_re,
    input  csr_num_t    csr_num,
    input  logic        csr_we,
    input  logic [31:0] csr_wmask,
    input  logic [31:0] csr_wvalue,
    input  logic        wb_ex,
    input  logic        ertn_flush,
    input  logic [5:0]  wb_ecode,
    input  logic [8:0]  wb_esubcode,
    input  logic [31:0] wb_pc,
    input  logic [31:0] wb_vaddr,
    output logic [31:0] csr_rvalue,
    output logic [31:0] ex_entry,
    output logic [31:0] ertn_pc,
    output logic        has_int
);

    // csr_re is part of the core interface only, reads are combinational
    csr_wr_t   wr;
    exc_req_t  exc;
    csr_sel_t  sel;
    exc_rd_t   exc_rd;
    timer_rd_t timer_rd;
    save_rd_t  save_rd;
    logic      timer_zero;

    assign wr.we         = csr_we;
    assign wr.wmask      = csr_wmask;
    assign wr.wvalue.raw = csr_wvalue;

    assign exc.ex       = wb_ex;
    assign exc.ertn     = ertn_flush;
    assign exc.ecode    = wb_ecode;
    assign exc.esubcode = wb_esubcode;
    assign exc.pc       = wb_pc;
    assign exc.vaddr    = wb_vaddr;

    csr_addr_decode i_decode (
        .csr_num (csr_num),
        .sel     (sel)
    );

    csr_exc_state i_exc_state (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .sel        (sel),
        .exc        (exc),
        .timer_zero (timer_zero),
        .rd         (exc_rd),
        .ex_entry   (ex_entry),
        .ertn_pc    (ertn_pc),
        .has_int    (has_int)
    );

    csr_timer i_timer (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .sel        (sel),
        .rd         (timer_rd),
        .timer_zero (timer_zero)
    );

    csr_save_regs i_save_regs (
        .clk   (clk),
        .reset (reset),
        .wr    (wr),
        .sel   (sel),
        .rd    (save_rd)
    );

    csr_read_mux i_read_mux (
        .sel      (sel),
        .exc_rd   (exc_rd),
        .timer_rd (timer_rd),
        .save_rd  (save_rd),
        .rvalue   (csr_rvalue)
    );

endmodule

// ==== tb_csr_top.sv ====
module tb_csr_top
    import csr_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 20;
    localparam int RANDOM_WRITES = 40;
    localparam int TIMER_LIMIT   = 64;
    localparam int TEST_CYCLES   = 5 + 2 * (RANDOM_WRITES + 40) + 4 * TIMER_LIMIT;
    localparam int WATCHDOG_NS   = TEST_CYCLES * CLK_PERIOD + 2000;
    localparam int RW_COUNT      = 8;
    localparam csr_num_t RW_REGS [RW_COUNT] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                                                CSR_TID, CSR_EENTRY, CSR_ERA, CSR_ECFG};

    logic        clk;
    logic        reset;
    logic        csr_re;
    csr_num_t    csr_num;
    logic        csr_we;
    logic [31:0] csr_wmask;
    logic [31:0] csr_wvalue;
    logic        wb_ex;
    logic        ertn_flush;
    logic [5:0]  wb_ecode;
    logic [8:0]  wb_esubcode;
    logic [31:0] wb_pc;
    logic [31:0] wb_vaddr;
    logic [31:0] csr_rvalue;
    logic [31:0] ex_entry;
    logic [31:0] ertn_pc;
    logic        has_int;

    int     errors;
    integer seed;
    logic   check_on;

    // Reference model state
    logic [1:0]  m_plv;
    logic        m_ie;
    logic [1:0]  m_pplv;
    logic        m_pie;
    logic [12:0] m_ecfg;
    logic [1:0]  m_is10;
    logic        m_tirq;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [31:0] m_eentry;
    logic [31:0] m_save [4];
    logic [31:0] m_tid;
    logic [31:0] m_tcfg;
    logic [31:0] m_count;

    logic [12:0] exp_is;
    logic [31:0] exp_rvalue;
    logic        exp_int;
    logic [31:0] wr_merged;

    csr_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .csr_re      (csr_re),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .ertn_flush  (ertn_flush),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .csr_rvalue  (csr_rvalue),
        .ex_entry    (ex_entry),
        .ertn_pc     (ertn_pc),
        .has_int     (has_int)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always_comb begin
        exp_is  = {1'b0, m_tirq, 9'b0, m_is10};
        exp_int = ((exp_is[11:0] & m_ecfg[11:0]) != 12'b0) && m_ie;
        case (csr_num)
            CSR_CRMD:   exp_rvalue = {28'b0, 1'b1, m_ie, m_plv};
            CSR_PRMD:   exp_rvalue = {29'b0, m_pie, m_pplv};
            CSR_ECFG:   exp_rvalue = {19'b0, m_ecfg};
            CSR_ESTAT:  exp_rvalue = {1'b0, m_esub, m_ecode, 3'b0, exp_is};
            CSR_ERA:    exp_rvalue = m_era;
            CSR_BADV:   exp_rvalue = m_badv;
            CSR_EENTRY: exp_rvalue = m_eentry;
            CSR_SAVE0:  exp_rvalue = m_save[0];
            CSR_SAVE1:  exp_rvalue = m_save[1];
            CSR_SAVE2:  exp_rvalue = m_save[2];
            CSR_SAVE3:  exp_rvalue = m_save[3];
            CSR_TID:    exp_rvalue = m_tid;
            CSR_TCFG:   exp_rvalue = m_tcfg;
            CSR_TVAL:   exp_rvalue = m_count;
            default:    exp_rvalue = 32'b0;
        endcase
        // Old read word with the masked bits replaced
        wr_merged = (exp_rvalue & ~csr_wmask) | (csr_wvalue & csr_wmask);
    end

    always @(posedge clk) begin
        if (reset) begin
            m_plv     <= 2'b0;
            m_ie      <= 1'b0;
            m_ecfg    <= 13'b0;
            m_is10    <= 2'b0;
            m_tirq    <= 1'b0;
            m_tcfg[0] <= 1'b0;
            m_count   <= TIMER_IDLE;
            m_tid     <= 32'b0;
        end else begin
            if (wb_ex) begin
                m_plv   <= 2'b0;
                m_ie    <= 1'b0;
                m_pplv  <= m_plv;
                m_pie   <= m_ie;
                m_era   <= wb_pc;
                m_ecode <= wb_ecode;
                m_esub  <= wb_esubcode;
                if (wb_ecode == ECODE_ADE && wb_esubcode == ESUBCODE_ADEF) begin
                    m_badv <= wb_pc;
                end else if (wb_ecode == ECODE_ADE || wb_ecode == ECODE_ALE) begin
                    m_badv <= wb_vaddr;
                end
            end else if (ertn_flush) begin
                m_plv <= m_pplv;
                m_ie  <= m_pie;
            end else if (csr_we) begin
                case (csr_num)
                    CSR_CRMD: begin
                        m_plv <= wr_merged[1:0];
                        m_ie  <= wr_merged[2];
                    end
                    CSR_PRMD: begin
                        m_pplv <= wr_merged[1:0];
                        m_pie  <= wr_merged[2];
                    end
                    CSR_ECFG:   m_ecfg    <= wr_merged[12:0];
                    CSR_ESTAT:  m_is10    <= wr_merged[1:0];
                    CSR_ERA:    m_era     <= wr_merged;
                    CSR_EENTRY: m_eentry  <= {wr_merged[31:6], 6'b0};
                    CSR_SAVE0:  m_save[0] <= wr_merged;
                    CSR_SAVE1:  m_save[1] <= wr_merged;
                    CSR_SAVE2:  m_save[2] <= wr_merged;
                    CSR_SAVE3:  m_save[3] <= wr_merged;
                    CSR_TID:    m_tid     <= wr_merged;
                    CSR_TCFG:   m_tcfg    <= wr_merged;
                    default: ;
                endcase
            end
            // Timer counts in steps of one from initval times four
            if (csr_we && csr_num == CSR_TCFG && wr_merged[0]) begin
                m_count <= {wr_merged[31:2], 2'b00};
            end else if (m_tcfg[0] && m_count != TIMER_IDLE) begin
                if (m_count == 32'b0 && m_tcfg[1]) begin
                    m_count <= {m_tcfg[31:2], 2'b00};
                end else begin
                    m_count <= m_count - 32'd1;
                end
            end
            if (m_count == 32'b0) begin
                m_tirq <= 1'b1;
            end else if (csr_we && csr_num == CSR_TICLR && csr_wmask[0] && csr_wvalue[0]) begin
                m_tirq <= 1'b0;
            end
        end
    end

    task automatic flag_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
        errors++;
        $display("[FAIL] %0t ns: %s is %h, model expects %h", $time, what, got, want);
    endtask

    a_rvalue: assert property (@(posedge clk) disable iff (reset || !check_on)
        csr_rvalue == exp_rvalue)
        else flag_mismatch("csr_rvalue", $sampled(csr_rvalue), $sampled(exp_rvalue));

    a_ex_entry: assert property (@(posedge clk) disable iff (reset || !check_on)
        ex_entry == m_eentry)
        else flag_mismatch("ex_entry", $sampled(ex_entry), $sampled(m_eentry));

    a_ertn_pc: assert property (@(posedge clk) disable iff (reset || !check_on)
        ertn_pc == m_era)
        else flag_mismatch("ertn_pc", $sampled(ertn_pc), $sampled(m_era));

    a_has_int: assert property (@(posedge clk) disable iff (reset || !check_on)
        has_int == exp_int)
        else flag_mismatch("has_int", {31'b0, $sampled(has_int)}, {31'b0, $sampled(exp_int)});

    // Leaves csr_num on the written register so the next edge checks readback
    task automatic csr_write(input csr_num_t num, input logic [31:0] mask,
                             input logic [31:0] value);
        @(negedge clk);
        csr_num    = num;
        csr_we     = 1'b1;
        csr_wmask  = mask;
        csr_wvalue = value;
        @(negedge clk);
        csr_we = 1'b0;
    endtask

    task automatic csr_select(input csr_num_t num);
        @(negedge clk);
        csr_num = num;
    endtask

    task automatic raise_exception(input logic [5:0] ecode, input logic [8:0] esub,
                                   input logic [31:0] pc, input logic [31:0] vaddr);
        @(negedge clk);
        wb_ex       = 1'b1;
        wb_ecode    = ecode;
        wb_esubcode = esub;
        wb_pc       = pc;
        wb_vaddr    = vaddr;
        @(negedge clk);
        wb_ex = 1'b0;
    endtask

    task automatic return_from_exception();
        @(negedge clk);
        ertn_flush = 1'b1;
        @(negedge clk);
        ertn_flush = 1'b0;
    endtask

    task automatic sweep_exc_regs();
        csr_select(CSR_CRMD);
        csr_select(CSR_PRMD);
        csr_select(CSR_ESTAT);
        csr_select(CSR_ERA);
        csr_select(CSR_BADV);
        csr_select(CSR_EENTRY);
    endtask

    task automatic wait_for_int(input int limit);
        int n;
        n = 0;
        while (!has_int && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!has_int) begin
            errors++;
            $display("has_int never rose within %0d cycles, stopped waiting at %0t ns",
                     limit, $time);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int idx;
        errors      = 0;
        seed        = 32'heb69_41e0;
        check_on    = 1'b0;
        reset       = 1'b1;
        csr_re      = 1'b0;
        csr_num     = CSR_CRMD;
        csr_we      = 1'b0;
        csr_wmask   = 32'b0;
        csr_wvalue  = 32'b0;
        wb_ex       = 1'b0;
        ertn_flush  = 1'b0;
        wb_ecode    = 6'b0;
        wb_esubcode = 9'b0;
        wb_pc       = 32'b0;
        wb_vaddr    = 32'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset  = 1'b0;
        csr_re = 1'b1;

        // Registers without reset get known contents first
        csr_write(CSR_EENTRY, 32'hffff_ffff, 32'h1c00_0000);
        csr_write(CSR_SAVE0, 32'hffff_ffff, 32'h0);
        csr_write(CSR_SAVE1, 32'hffff_ffff, 32'h0);
        csr_write(CSR_SAVE2, 32'hffff_ffff, 32'h0);
        csr_write(CSR_SAVE3, 32'hffff_ffff, 32'h0);
        csr_write(CSR_TCFG, 32'hffff_ffff, 32'h0);
        raise_exception(ECODE_ADE, ESUBCODE_ADEF, 32'h1c00_0100, 32'h0);
        check_on = 1'b1;

        for (int i = 0; i < RANDOM_WRITES; i++) begin
            idx = i % RW_COUNT;
            csr_write(RW_REGS[idx], $random(seed), $random(seed));
        end
        csr_select(CSR_CRMD);
        csr_select(14'h2a5);
        csr_select(CSR_TICLR);

        // Exception entry and return
        csr_write(CSR_CRMD, 32'h7, 32'h7);
        raise_exception(ECODE_ADE, ESUBCODE_ADEF, $random(seed), $random(seed));
        sweep_exc_regs();
        return_from_exception();
        sweep_exc_regs();
        raise_exception(ECODE_ALE, 9'h000, $random(seed), $random(seed));
        sweep_exc_regs();
        return_from_exception();
        csr_write(CSR_CRMD, 32'h7, 32'h1);
        raise_exception(ECODE_ADE, 9'h001, $random(seed), $random(seed));
        sweep_exc_regs();
        raise_exception(6'h0b, 9'h000, $random(seed), $random(seed));
        sweep_exc_regs();
        return_from_exception();
        sweep_exc_regs();

        // One-shot timer
        csr_write(CSR_ECFG, 32'h1fff, 32'h800);
        csr_write(CSR_CRMD, 32'h4, 32'h4);
        csr_write(CSR_TCFG, 32'hffff_ffff, {30'd5, 1'b0, 1'b1});
        csr_select(CSR_TVAL);
        wait_for_int(TIMER_LIMIT);
        repeat (4) @(negedge clk);
        csr_select(CSR_ESTAT);
        csr_write(CSR_TICLR, 32'h1, 32'h1);
        csr_select(CSR_ESTAT);

        // Periodic timer over two rounds
        csr_write(CSR_TCFG, 32'hffff_ffff, {30'd3, 1'b1, 1'b1});
        csr_select(CSR_TVAL);
        wait_for_int(TIMER_LIMIT);
        csr_write(CSR_TICLR, 32'h1, 32'h1);
        csr_select(CSR_TVAL);
        wait_for_int(TIMER_LIMIT);
        csr_write(CSR_TCFG, 32'h1, 32'h0);
        csr_write(CSR_TICLR, 32'h1, 32'h1);
        csr_select(CSR_TVAL);
        repeat (3) @(negedge clk);

        // Software interrupt bits
        csr_write(CSR_ECFG, 32'h1fff, 32'h1);
        csr_write(CSR_ESTAT, 32'h3, 32'h2);
        csr_write(CSR_ESTAT, 32'h3, 32'h1);
        csr_write(CSR_ESTAT, 32'h1ffc, 32'h1ffc);
        csr_write(CSR_CRMD, 32'h4, 32'h0);
        csr_write(CSR_ECFG, 32'h3, 32'h3);
        csr_write(CSR_CRMD, 32'h4, 32'h4);
        csr_write(CSR_ESTAT, 32'h3, 32'h2);
        csr_write(CSR_ESTAT, 32'h3, 32'h0);
        repeat (2) @(negedge clk);

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== csr_top.f ====
csr_pkg.sv
csr_addr_decode.sv
csr_exc_state.sv
csr_timer.sv
csr_save_regs.sv
csr_read_mux.sv
csr_top.sv
tb_csr_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
    --top-module tb_csr_top -f csr_top.f

./obj_dir/Vtb_csr_top | tee sim.log

grep -q "Simulation passed" sim.log
